//--- logic/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ------------------------------------------------------------
    // tilelink-ul opcodes.
    // ------------------------------------------------------------

    // a channel requests that the slave port understands.
    typedef enum logic [2:0] {
        put_full = 3'd0,
        get      = 3'd4
    } tl_a_opcode_e;

    // d channel responses, one beat each.
    typedef enum logic [2:0] {
        access_ack      = 3'd0,
        access_ack_data = 3'd1
    } tl_d_opcode_e;

    // bus controller holds one request at a time.
    typedef enum logic {
        idle    = 1'b0,
        respond = 1'b1
    } ctrl_state_e;

    // ------------------------------------------------------------
    // 16550 register map.
    // ------------------------------------------------------------

    // offsets 0 and 1 switch to the divisor latch when dlab is set.
    typedef enum logic [2:0] {
        thr_rbr_dll = 3'd0,
        ier_dlm     = 3'd1,
        iir_fcr     = 3'd2,
        lcr         = 3'd3,
        mcr         = 3'd4,
        lsr         = 3'd5,
        msr         = 3'd6,
        scr         = 3'd7
    } reg_addr_e;

    // line status bits.
    localparam logic [7:0] LSR_THRE = 8'h20;
    localparam logic [7:0] LSR_TEMT = 8'h40;

    // divisor latch access bit in lcr.
    localparam int LCR_DLAB_BIT = 7;

    // ------------------------------------------------------------
    // sizes.
    // ------------------------------------------------------------
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;
    localparam int SOURCE_W   = 4;
    localparam int DIVISOR_W  = 16;
    localparam int FRAME_BITS = 10;   // start, 8 data, stop.
    localparam int BIT_CNT_W  = 4;

    // one a channel beat.
    typedef struct packed {
        tl_a_opcode_e        opcode;
        logic [1:0]          size;
        logic [SOURCE_W-1:0] source;
        logic [2:0]          address;
        logic [7:0]          data;
    } tl_a_t;

    // one d channel beat.
    typedef struct packed {
        tl_d_opcode_e        opcode;
        logic [1:0]          size;
        logic [SOURCE_W-1:0] source;
        logic                denied;
        logic [7:0]          data;
    } tl_d_t;

endpackage

`default_nettype wire

//--- logic/uart_bus_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uart_bus_ctrl (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              a_valid,
    input  wire uart_pkg::tl_a_t             a_beat,
    output logic                             a_ready,
    output logic                             d_valid,
    output uart_pkg::tl_d_t                  d_beat,
    input  wire                              d_ready,
    input  wire                              fifo_full,
    input  wire                              fifo_empty,
    input  wire                              tx_busy,
    output logic                             push,
    output logic [7:0]                       push_data,
    output logic [uart_pkg::DIVISOR_W-1:0]   divisor
);
    import uart_pkg::*;

    ctrl_state_e state_q;
    logic [7:0]  lcr_q;
    logic [7:0]  dll_q;
    logic [7:0]  dlm_q;
    logic [7:0]  scr_q;
    reg_addr_e   addr;
    logic        accept;
    logic        dlab;
    logic        is_put;
    logic        is_get;
    logic        thr_write;
    logic [7:0]  lsr_val;
    logic [7:0]  rd_data;

    // ------------------------------------------------------------
    // handshake and decode.
    // ------------------------------------------------------------

    // a channel is open only while no response is pending.
    assign a_ready = (state_q == idle);
    assign d_valid = (state_q == respond);
    assign accept  = a_valid && a_ready;

    assign addr   = reg_addr_e'(a_beat.address);
    assign dlab   = lcr_q[LCR_DLAB_BIT];
    assign is_put = (a_beat.opcode == put_full);
    assign is_get = (a_beat.opcode == get);

    // thr write only when the divisor latch is not mapped in.
    assign thr_write = is_put && (addr == thr_rbr_dll) && !dlab;
    assign push      = accept && thr_write && !fifo_full;
    assign push_data = a_beat.data;

    assign divisor = {dlm_q, dll_q};

    // live line status.
    // thre means room in the fifo, temt means nothing left to send.
    assign lsr_val = (fifo_full ? 8'h00 : LSR_THRE)
                   | ((fifo_empty && !tx_busy) ? LSR_TEMT : 8'h00);

    // read mux, unimplemented registers read as zero.
    always_comb begin
        case (addr)
            thr_rbr_dll: rd_data = dlab ? dll_q : 8'h00;
            ier_dlm:     rd_data = dlab ? dlm_q : 8'h00;
            lcr:         rd_data = lcr_q;
            lsr:         rd_data = lsr_val;
            scr:         rd_data = scr_q;
            default:     rd_data = 8'h00;
        endcase
    end

    // ------------------------------------------------------------
    // state machine.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            case (state_q)
                idle: begin
                    if (a_valid) begin
                        state_q <= respond;
                    end
                end
                respond: begin
                    // back to idle on the edge the d beat leaves.
                    if (d_ready) begin
                        state_q <= idle;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // register file, written on the accepting edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lcr_q <= 8'h00;
            dll_q <= 8'h01;
            dlm_q <= 8'h00;
            scr_q <= 8'h00;
        end else if (accept && is_put) begin
            case (addr)
                thr_rbr_dll: begin
                    if (dlab) begin
                        dll_q <= a_beat.data;
                    end
                end
                ier_dlm: begin
                    if (dlab) begin
                        dlm_q <= a_beat.data;
                    end
                end
                lcr:     lcr_q <= a_beat.data;
                scr:     scr_q <= a_beat.data;
                // ier, fcr and mcr writes are acked and ignored.
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------
    // d beat, built when the request is taken.
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            d_beat.size   <= a_beat.size;
            d_beat.source <= a_beat.source;
            if (is_get) begin
                d_beat.opcode <= access_ack_data;
                d_beat.denied <= 1'b0;
                d_beat.data   <= rd_data;
            end else if (is_put) begin
                // a full fifo drops the byte and denies the write.
                d_beat.opcode <= access_ack;
                d_beat.denied <= thr_write && fifo_full;
                d_beat.data   <= 8'h00;
            end else begin
                d_beat.opcode <= access_ack;
                d_beat.denied <= 1'b1;
                d_beat.data   <= 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_tx_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_fifo (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        push,
    input  wire  [7:0] push_data,
    output logic       full,
    output logic       empty,
    input  wire        pop,
    output logic [7:0] pop_data
);
    import uart_pkg::*;

    logic [7:0]          mem [FIFO_DEPTH];
    logic [FIFO_PTR_W:0] wr_ptr_q;
    logic [FIFO_PTR_W:0] rd_ptr_q;
    logic                do_push;
    logic                do_pop;

    // pointers carry one extra wrap bit.
    // equal index with different wrap bits means full.
    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[FIFO_PTR_W] != rd_ptr_q[FIFO_PTR_W])
                && (wr_ptr_q[FIFO_PTR_W-1:0] == rd_ptr_q[FIFO_PTR_W-1:0]);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // head of the queue, valid the cycle after a push.
    assign pop_data = mem[rd_ptr_q[FIFO_PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q[FIFO_PTR_W-1:0]] <= push_data;
        end
    end

    // push and pop may land on the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_tx_serializer.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_serializer (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [uart_pkg::DIVISOR_W-1:0]   divisor,
    input  wire                              fifo_empty,
    input  wire  [7:0]                       pop_data,
    output logic                             pop,
    output logic                             busy,
    output logic                             tx
);
    import uart_pkg::*;

    logic [FRAME_BITS-1:0] shift_q;
    logic [DIVISOR_W-1:0]  baud_cnt_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic                  bit_done;
    logic                  last_bit;

    // take a byte in the first idle cycle with data waiting.
    assign pop = !busy && !fifo_empty;

    // counter runs divisor down to zero, so divisor+1 cycles per bit.
    assign bit_done = (baud_cnt_q == '0);
    assign last_bit = (bit_cnt_q == BIT_CNT_W'(FRAME_BITS - 1));

    // line comes straight from the shift register.
    // it idles at all ones.
    assign tx = shift_q[0];

    // ------------------------------------------------------------
    // frame shifter.
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q    <= '1;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            busy       <= 1'b0;
        end else if (!busy) begin
            if (pop) begin
                // stop bit, data lsb first, start bit at bit 0.
                shift_q    <= {1'b1, pop_data, 1'b0};
                baud_cnt_q <= divisor;
                bit_cnt_q  <= '0;
                busy       <= 1'b1;
            end
        end else if (bit_done) begin
            // next bit, ones fill in from the top.
            shift_q    <= {1'b1, shift_q[FRAME_BITS-1:1]};
            baud_cnt_q <= divisor;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (last_bit) begin
                // stop bit has ended.
                busy <= 1'b0;
            end
        end else begin
            baud_cnt_q <= baud_cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_top.sv
`timescale 1ns/100ps
`default_nettype none

module uart_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    a_valid,
    input  wire uart_pkg::tl_a_t   a_beat,
    output logic                   a_ready,
    output logic                   d_valid,
    output uart_pkg::tl_d_t        d_beat,
    input  wire                    d_ready,
    output logic                   tx
);
    import uart_pkg::*;

    // controller to fifo.
    logic                 push;
    logic [7:0]           push_data;
    logic                 fifo_full;
    logic                 fifo_empty;

    // fifo to serializer.
    logic                 pop;
    logic [7:0]           pop_data;

    // serializer status and baud setting.
    logic                 tx_busy;
    logic [DIVISOR_W-1:0] divisor;

    // ------------------------------------------------------------
    // bus side.
    // ------------------------------------------------------------
    uart_bus_ctrl bus_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_valid    (a_valid),
        .a_beat     (a_beat),
        .a_ready    (a_ready),
        .d_valid    (d_valid),
        .d_beat     (d_beat),
        .d_ready    (d_ready),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .tx_busy    (tx_busy),
        .push       (push),
        .push_data  (push_data),
        .divisor    (divisor)
    );

    // ------------------------------------------------------------
    // transmit datapath.
    // ------------------------------------------------------------
    uart_tx_fifo tx_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (fifo_full),
        .empty     (fifo_empty),
        .pop       (pop),
        .pop_data  (pop_data)
    );

    uart_tx_serializer tx_serializer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .divisor    (divisor),
        .fifo_empty (fifo_empty),
        .pop_data   (pop_data),
        .pop        (pop),
        .busy       (tx_busy),
        .tx         (tx)
    );

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);
    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 16 cycles, released just after an edge.
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/uart_sva.sv
`timescale 1ns/100ps
`default_nettype none

module uart_sva (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  a_ready,
    input wire                  d_valid,
    input wire                  d_ready,
    input wire uart_pkg::tl_d_t d_beat,
    input wire                  tx,
    input wire                  busy
);
    // ------------------------------------------------------------
    // bus handshake.
    // ------------------------------------------------------------

    // a stalled d beat keeps its contents.
    d_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (d_valid && !d_ready) |=> $stable(d_beat))
        else $error("d beat changed while stalled");

    // only one request in flight.
    one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        !(a_ready && d_valid))
        else $error("a_ready and d_valid high together");

    // line idles high between frames.
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> tx)
        else $error("tx low while the serializer is idle");

endmodule

`default_nettype wire

//--- testbench/uart_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tb;
    import uart_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       a_valid;
    tl_a_t      a_beat;
    logic       a_ready;
    logic       d_valid;
    tl_d_t      d_beat;
    logic       d_ready;
    logic       tx;

    // one request and one expected response per trace line.
    tl_a_t       req_q[$];
    tl_d_t       rsp_q[$];
    logic [15:0] div_after_q[$];
    logic        waits_idle_q[$];
    logic        queues_byte_q[$];

    logic [7:0]  tx_exp_q[$];
    logic [15:0] cur_divisor;
    logic        in_frame;
    logic [31:0] rng_state;
    int          cycle_count;
    int          timeout_cycles;

    clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_top uart_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_valid (a_valid),
        .a_beat  (a_beat),
        .a_ready (a_ready),
        .d_valid (d_valid),
        .d_beat  (d_beat),
        .d_ready (d_ready),
        .tx      (tx)
    );

    bind uart_top uart_sva uart_sva_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_ready (a_ready),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d_beat  (d_beat),
        .tx      (tx),
        .busy    (tx_busy)
    );

    // ------------------------------------------------------------
    // error handling and checks.
    // ------------------------------------------------------------
    task automatic end_with_failure(input string text);
        $display("%s", text);
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_d_beat(input tl_d_t got, input tl_d_t exp, input string what);
        if (got !== exp) begin
            end_with_failure($sformatf("Fail at %0t ns: %s d beat %h, expected %h",
                                       $time, what, got, exp));
        end
    endtask

    task automatic check_tx_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            end_with_failure($sformatf("Fail at %0t ns: tx byte %h, expected %h",
                                       $time, got, exp));
        end
    endtask

    // 32-bit xorshift for the d_ready stall pattern.
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------------------------------------
    // trace loading.
    // ------------------------------------------------------------
    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op, ad, da, sr, sz, dn, rd;
        logic [7:0]  lcr_m;
        logic [15:0] div_m;
        int          max_div;
        tl_a_t       req;
        tl_d_t       rsp;
        logic        is_put;
        logic        dlab;
        lcr_m   = 8'h00;
        div_m   = 16'd1;
        max_div = 1;
        fd = $fopen("testbench/uart_trace.txt", "r");
        if (fd == 0) begin
            end_with_failure("could not open the trace file testbench/uart_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h", op, ad, da, sr, sz, dn, rd);
            if (n == 7) begin
                req.opcode  = tl_a_opcode_e'(op[2:0]);
                req.size    = sz[1:0];
                req.source  = sr[SOURCE_W-1:0];
                req.address = ad[2:0];
                req.data    = da;
                // a get answers with data and everything else with a plain ack.
                rsp.opcode  = (req.opcode == get) ? access_ack_data : access_ack;
                rsp.size    = req.size;
                rsp.source  = req.source;
                rsp.denied  = dn[0];
                rsp.data    = rd;
                is_put = (req.opcode == put_full);
                dlab   = lcr_m[LCR_DLAB_BIT];
                // divisor changes wait for an idle line.
                waits_idle_q.push_back((is_put && dlab && ad[2:1] == 2'b00)
                    || (req.opcode == get && ad[2:0] == lsr && (rd & LSR_TEMT) != 8'h00));
                queues_byte_q.push_back(is_put && ad[2:0] == thr_rbr_dll && !dlab && !dn[0]);
                if (is_put && ad[2:0] == lcr) begin
                    lcr_m = da;
                end else if (is_put && dlab && ad[2:0] == thr_rbr_dll) begin
                    div_m[7:0] = da;
                end else if (is_put && dlab && ad[2:0] == ier_dlm) begin
                    div_m[15:8] = da;
                end
                if (is_put && ad[2:0] == thr_rbr_dll && !dlab && int'(div_m) > max_div) begin
                    max_div = int'(div_m);
                end
                div_after_q.push_back(div_m);
                req_q.push_back(req);
                rsp_q.push_back(rsp);
            end
        end
        $fclose(fd);
        timeout_cycles = 40 * req_q.size() * 10 * (max_div + 1);
    endtask

    // ------------------------------------------------------------
    // bus driver.
    // ------------------------------------------------------------
    task automatic wait_line_idle();
        while (tx_exp_q.size() != 0 || in_frame) begin
            @(posedge clk);
        end
        // let the stop bit run out so the serializer drops busy.
        repeat (int'(cur_divisor) + 4) @(posedge clk);
        #2;
    endtask

    task automatic run_request(input int idx);
        tl_d_t held;
        tl_d_t got;
        logic  accepted;
        logic  taken;
        logic  stalled;
        if (waits_idle_q[idx]) begin
            wait_line_idle();
        end
        if (queues_byte_q[idx]) begin
            tx_exp_q.push_back(req_q[idx].data);
        end
        a_valid  = 1'b1;
        a_beat   = req_q[idx];
        accepted = 1'b0;
        while (!accepted) begin
            accepted = a_ready;
            @(posedge clk);
            #2;
        end
        a_valid = 1'b0;
        a_beat  = '0;
        taken   = 1'b0;
        stalled = 1'b0;
        while (!taken) begin
            rng_state = next_random(rng_state);
            d_ready   = (rng_state[1:0] != 2'b00);
            if (!d_valid) begin
                end_with_failure("d_valid was low while a response was owed");
            end
            if (a_ready) begin
                end_with_failure("a_ready was high while a response was pending");
            end
            // a stalled beat must not move.
            if (stalled) begin
                check_d_beat(d_beat, held, "stalled");
            end
            held    = d_beat;
            stalled = 1'b1;
            taken   = d_ready;
            got     = d_beat;
            @(posedge clk);
            #2;
        end
        d_ready = 1'b0;
        check_d_beat(got, rsp_q[idx], "response");
        cur_divisor = div_after_q[idx];
    endtask

    // ------------------------------------------------------------
    // serial line monitor.
    // ------------------------------------------------------------

    // samples mid-bit on falling clock edges.
    initial begin : line_monitor
        logic [7:0] got;
        int         bit_cycles;
        @(posedge rst_n);
        forever begin
            @(negedge tx);
            in_frame   = 1'b1;
            bit_cycles = int'(cur_divisor) + 1;
            repeat ((bit_cycles + 1) / 2) @(negedge clk);
            if (tx !== 1'b0) begin
                end_with_failure("start bit on tx did not stay low");
            end
            repeat (8) begin
                repeat (bit_cycles) @(negedge clk);
                got = {tx, got[7:1]};
            end
            repeat (bit_cycles) @(negedge clk);
            if (tx !== 1'b1) begin
                end_with_failure("stop bit on tx was missing");
            end
            if (tx_exp_q.size() == 0) begin
                end_with_failure("a frame appeared on tx that was never written");
            end
            check_tx_byte(got, tx_exp_q.pop_front());
            in_frame = 1'b0;
        end
    end

    // run limit in clock cycles.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            end_with_failure("simulation timed out before the trace completed");
        end
    end

    initial begin : stimulus
        a_valid        = 1'b0;
        a_beat         = '0;
        d_ready        = 1'b0;
        cur_divisor    = 16'd1;
        in_frame       = 1'b0;
        rng_state      = 32'd24;
        cycle_count    = 0;
        timeout_cycles = 0;
        load_trace();
        @(posedge rst_n);
        @(posedge clk);
        #2;
        for (int idx = 0; idx < req_q.size(); idx++) begin
            run_request(idx);
        end
        wait_line_idle();
        if (tx !== 1'b1) begin
            end_with_failure("tx did not return high after the last frame");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/uart_trace.txt
# columns (hex): opcode address data source size denied read_data
# opcode 0 put_full, 4 get, 2 unknown; one bus request per line
4 5 00 1 0 0 60
4 7 00 2 0 0 00
0 7 a5 3 0 0 00
4 7 00 4 1 0 a5
0 0 55 5 0 0 00
0 0 c3 6 0 0 00
0 0 01 7 0 0 00
0 3 80 8 0 0 00
0 0 10 9 0 0 00
0 1 5a a 0 0 00
4 0 00 b 0 0 10
4 1 00 c 0 0 5a
0 1 00 d 0 0 00
0 3 03 e 0 0 00
4 3 00 f 2 0 03
0 0 11 1 0 0 00
0 0 22 2 0 0 00
0 0 33 3 0 0 00
0 0 44 4 0 0 00
0 0 55 5 0 0 00
0 0 66 6 0 1 00
4 5 00 7 0 0 00
2 7 00 8 2 1 00
4 7 00 9 0 0 a5
4 5 00 a 0 0 60

//--- all.f
logic/uart_pkg.sv
logic/uart_bus_ctrl.sv
logic/uart_tx_fifo.sv
logic/uart_tx_serializer.sv
logic/uart_top.sv
testbench/clock_gen.sv
testbench/uart_sva.sv
testbench/uart_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator and run it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module uart_tb \
    --Mdir obj_dir \
    -o uart_sim \
    -f all.f

./obj_dir/uart_sim
